//--- hazardPkg.sv
`default_nettype none

package hazardPkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////////////////////////

	// Tuse and Tnew range over 0..3
	localparam int timeW = 2;
	localparam int regW = 5;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opBlez    = 6'h06,
		opBgtz    = 6'h07,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opSltiu   = 6'h0b,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opXori    = 6'h0e,
		opLui     = 6'h0f,
		opLb      = 6'h20,
		opLh      = 6'h21,
		opLw      = 6'h23,
		opLbu     = 6'h24,
		opLhu     = 6'h25,
		opSb      = 6'h28,
		opSh      = 6'h29,
		opSw      = 6'h2b
	} opcodeT;

	// Function field of special opcode, instr[5:0]
	typedef enum logic [5:0] {
		fnSll   = 6'h00, fnSrl   = 6'h02, fnSra  = 6'h03,
		fnSllv  = 6'h04, fnSrlv  = 6'h06, fnSrav = 6'h07,
		fnJr    = 6'h08, fnJalr  = 6'h09,
		fnMfhi  = 6'h10, fnMthi  = 6'h11, fnMflo = 6'h12, fnMtlo = 6'h13,
		fnMult  = 6'h18, fnMultu = 6'h19, fnDiv  = 6'h1a, fnDivu = 6'h1b,
		fnAdd   = 6'h20, fnAddu  = 6'h21, fnSub  = 6'h22, fnSubu = 6'h23,
		fnAnd   = 6'h24, fnOr    = 6'h25, fnXor  = 6'h26, fnNor  = 6'h27,
		fnSlt   = 6'h2a, fnSltu  = 6'h2b
	} functT;

	// rt field of regimm opcode
	typedef enum logic [4:0] {
		rtBltz = 5'h00,
		rtBgez = 5'h01
	} regimmT;

	//////////////////////////////////////////////////////////////////////
	// Forwarding mux select
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdE   = 2'd1,
		fwdM   = 2'd2,
		fwdW   = 2'd3
	} fwdSelT;

endpackage

`default_nettype wire

//--- atDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module atDecoder
	import hazardPkg::*;
(
	input  logic [31:0]      instr,
	output logic [regW-1:0]  rsAddr,
	output logic [timeW-1:0] rsTuse,
	output logic [regW-1:0]  rtAddr,
	output logic [timeW-1:0] rtTuse,
	output logic [regW-1:0]  dstAddr,
	output logic [timeW-1:0] dstTnew,
	output logic             mduReq
);

	localparam logic [regW-1:0] regZero = 5'd0;
	// Link register for jal
	localparam logic [regW-1:0] regRa = 5'd31;

	opcodeT opcode;
	functT funct;
	regimmT rtCode;
	logic [regW-1:0] rs;
	logic [regW-1:0] rt;
	logic [regW-1:0] rd;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct = functT'(instr[5:0]);
	assign rtCode = regimmT'(instr[20:16]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	//////////////////////////////////////////////////////////////////////
	// Source/destination table
	//////////////////////////////////////////////////////////////////////

	// Each row is {rs, Tuse, rt, Tuse, dst, Tnew}
	always_comb
	begin
		{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} = '0;
		mduReq = 1'b0;
		case (opcode)
			opSpecial:
			begin
				case (funct)
					fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
					fnSllv, fnSrlv, fnSrav, fnSlt, fnSltu:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{rs, 2'd1, rt, 2'd1, rd, 2'd2};
					// Shift amount is an immediate, rs unused
					fnSll, fnSrl, fnSra:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{regZero, 2'd0, rt, 2'd1, rd, 2'd2};
					fnMult, fnMultu, fnDiv, fnDivu:
					begin
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{rs, 2'd1, rt, 2'd1, regZero, 2'd0};
						mduReq = 1'b1;
					end
					fnMfhi, fnMflo:
					begin
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{regZero, 2'd0, regZero, 2'd0, rd, 2'd2};
						mduReq = 1'b1;
					end
					fnMthi, fnMtlo:
					begin
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{rs, 2'd1, regZero, 2'd0, regZero, 2'd0};
						mduReq = 1'b1;
					end
					// Jump target needed in decode
					fnJr:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{rs, 2'd0, regZero, 2'd0, regZero, 2'd0};
					fnJalr:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{rs, 2'd0, regZero, 2'd0, rd, 2'd1};
					default:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} = '0;
				endcase
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{rs, 2'd1, regZero, 2'd0, rt, 2'd2};
			opLui:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{regZero, 2'd0, regZero, 2'd0, rt, 2'd1};
			// Load data available after memory stage
			opLb, opLbu, opLh, opLhu, opLw:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{rs, 2'd1, regZero, 2'd0, rt, 2'd3};
			// Store data not needed until memory stage
			opSb, opSh, opSw:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{rs, 2'd1, rt, 2'd2, regZero, 2'd0};
			opBeq, opBne:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{rs, 2'd0, rt, 2'd0, regZero, 2'd0};
			opBlez, opBgtz:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{rs, 2'd0, regZero, 2'd0, regZero, 2'd0};
			opRegimm:
			begin
				case (rtCode)
					rtBltz, rtBgez:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
							{rs, 2'd0, regZero, 2'd0, regZero, 2'd0};
					default:
						{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} = '0;
				endcase
			end
			opJal:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} =
					{regZero, 2'd0, regZero, 2'd0, regRa, 2'd1};
			// j touches no register, falls to default
			default:
				{rsAddr, rsTuse, rtAddr, rtTuse, dstAddr, dstTnew} = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- stageTracker.sv
`timescale 1ns/1ns
`default_nettype none

module stageTracker
	import hazardPkg::*;
(
	input  logic             clk,
	input  logic             arstN,
	input  logic             stall,
	input  logic [regW-1:0]  dstAddr,
	input  logic [regW-1:0]  rsAddr,
	input  logic [regW-1:0]  rtAddr,
	input  logic [timeW-1:0] dstTnew,
	output logic [regW-1:0]  dstE,
	output logic [regW-1:0]  dstM,
	output logic [regW-1:0]  dstW,
	output logic [regW-1:0]  rsE,
	output logic [regW-1:0]  rtE,
	output logic [timeW-1:0] tnewE,
	output logic [timeW-1:0] tnewM
);

	logic [timeW-1:0] tnewNextE;
	logic [timeW-1:0] tnewNextM;

	// One cycle of ageing per stage, stops at zero
	assign tnewNextE = (dstTnew == '0) ? '0 : dstTnew - timeW'(1);
	assign tnewNextM = (tnewE == '0) ? '0 : tnewE - timeW'(1);

	//////////////////////////////////////////////////////////////////////
	// Execute record
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			dstE <= '0;
			tnewE <= '0;
			rsE <= '0;
			rtE <= '0;
		end
		else if (stall)
		begin
			// Bubble while decode is held
			dstE <= '0;
			tnewE <= '0;
			rsE <= '0;
			rtE <= '0;
		end
		else
		begin
			dstE <= dstAddr;
			tnewE <= tnewNextE;
			rsE <= rsAddr;
			rtE <= rtAddr;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory and writeback records
	//////////////////////////////////////////////////////////////////////

	// These always advance, stall only affects execute
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			dstM <= '0;
			tnewM <= '0;
			dstW <= '0;
		end
		else
		begin
			dstM <= dstE;
			tnewM <= tnewNextM;
			dstW <= dstM;
		end
	end

endmodule

`default_nettype wire

//--- stallControl.sv
`timescale 1ns/1ns
`default_nettype none

module stallControl
	import hazardPkg::*;
(
	input  logic [regW-1:0]  rsAddr,
	input  logic [regW-1:0]  rtAddr,
	input  logic [regW-1:0]  dstE,
	input  logic [regW-1:0]  dstM,
	input  logic [timeW-1:0] rsTuse,
	input  logic [timeW-1:0] rtTuse,
	input  logic [timeW-1:0] tnewE,
	input  logic [timeW-1:0] tnewM,
	input  logic             mduReq,
	input  logic             mduBusy,
	output logic             stall
);

	logic rsStall;
	logic rtStall;
	logic mduStall;

	// Source needed before an in-flight producer has its result
	function automatic logic srcLate(
		input logic [regW-1:0]  addr,
		input logic [timeW-1:0] tuse
	);
		logic hitE;
		logic hitM;
		hitE = (addr == dstE) && (tnewE > tuse);
		hitM = (addr == dstM) && (tnewM > tuse);
		return (addr != '0) && (hitE || hitM);
	endfunction

	always_comb
	begin
		rsStall = srcLate(rsAddr, rsTuse);
		rtStall = srcLate(rtAddr, rtTuse);
		// hi/lo access must wait for the multiplier
		mduStall = mduReq && mduBusy;
		stall = rsStall || rtStall || mduStall;
	end

endmodule

`default_nettype wire

//--- forwardSelect.sv
`timescale 1ns/1ns
`default_nettype none

module forwardSelect
	import hazardPkg::*;
(
	input  logic [regW-1:0]  rsAddr,
	input  logic [regW-1:0]  rtAddr,
	input  logic [regW-1:0]  rsE,
	input  logic [regW-1:0]  rtE,
	input  logic [regW-1:0]  dstE,
	input  logic [regW-1:0]  dstM,
	input  logic [regW-1:0]  dstW,
	input  logic [timeW-1:0] tnewE,
	input  logic [timeW-1:0] tnewM,
	output fwdSelT           fwdRsD,
	output fwdSelT           fwdRtD,
	output fwdSelT           fwdRsE,
	output fwdSelT           fwdRtE
);

	// Newest matching stage wins, forwarded only once its value exists.
	// Execute operands skip the E record since that is themselves
	function automatic fwdSelT pickSource(
		input logic [regW-1:0] addr,
		input logic            lookE
	);
		fwdSelT sel;
		sel = fwdReg;
		if (addr == '0)
			sel = fwdReg;
		else if (lookE && (addr == dstE))
			sel = (tnewE == '0) ? fwdE : fwdReg;
		else if (addr == dstM)
			sel = (tnewM == '0) ? fwdM : fwdReg;
		else if (addr == dstW)
			sel = fwdW;
		return sel;
	endfunction

	// Decode operands
	always_comb
	begin
		fwdRsD = pickSource(rsAddr, 1'b1);
		fwdRtD = pickSource(rtAddr, 1'b1);
	end

	// Execute operands
	always_comb
	begin
		fwdRsE = pickSource(rsE, 1'b0);
		fwdRtE = pickSource(rtE, 1'b0);
	end

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit
	import hazardPkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	input  logic [31:0] instrD,
	input  logic        mduBusy,
	output logic        stall,
	output fwdSelT      fwdRsD,
	output fwdSelT      fwdRtD,
	output fwdSelT      fwdRsE,
	output fwdSelT      fwdRtE
);

	// Decode stage fields
	logic [regW-1:0] rsAddr;
	logic [regW-1:0] rtAddr;
	logic [regW-1:0] dstAddr;
	logic [timeW-1:0] rsTuse;
	logic [timeW-1:0] rtTuse;
	logic [timeW-1:0] dstTnew;
	logic mduReq;

	// In-flight records
	logic [regW-1:0] dstE;
	logic [regW-1:0] dstM;
	logic [regW-1:0] dstW;
	logic [regW-1:0] rsE;
	logic [regW-1:0] rtE;
	logic [timeW-1:0] tnewE;
	logic [timeW-1:0] tnewM;

	atDecoder dec0 (
		.instr   (instrD),
		.rsAddr  (rsAddr),
		.rsTuse  (rsTuse),
		.rtAddr  (rtAddr),
		.rtTuse  (rtTuse),
		.dstAddr (dstAddr),
		.dstTnew (dstTnew),
		.mduReq  (mduReq)
	);

	stageTracker trk0 (
		.clk     (clk),
		.arstN   (arstN),
		.stall   (stall),
		.dstAddr (dstAddr),
		.rsAddr  (rsAddr),
		.rtAddr  (rtAddr),
		.dstTnew (dstTnew),
		.dstE    (dstE),
		.dstM    (dstM),
		.dstW    (dstW),
		.rsE     (rsE),
		.rtE     (rtE),
		.tnewE   (tnewE),
		.tnewM   (tnewM)
	);

	stallControl stl0 (
		.rsAddr  (rsAddr),
		.rtAddr  (rtAddr),
		.dstE    (dstE),
		.dstM    (dstM),
		.rsTuse  (rsTuse),
		.rtTuse  (rtTuse),
		.tnewE   (tnewE),
		.tnewM   (tnewM),
		.mduReq  (mduReq),
		.mduBusy (mduBusy),
		.stall   (stall)
	);

	forwardSelect fwd0 (
		.rsAddr (rsAddr),
		.rtAddr (rtAddr),
		.rsE    (rsE),
		.rtE    (rtE),
		.dstE   (dstE),
		.dstM   (dstM),
		.dstW   (dstW),
		.tnewE  (tnewE),
		.tnewM  (tnewM),
		.fwdRsD (fwdRsD),
		.fwdRtD (fwdRtD),
		.fwdRsE (fwdRsE),
		.fwdRtE (fwdRtE)
	);

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
	parameter int halfPeriod = 10,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic arstN
);

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Release away from the rising edge
	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- tbHazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module tbHazardUnit
	import hazardPkg::*;
();

	logic clk;
	logic arstN;
	logic [31:0] instrD;
	logic mduBusy;
	logic stall;
	fwdSelT fwdRsD;
	fwdSelT fwdRtD;
	fwdSelT fwdRsE;
	fwdSelT fwdRtE;
	int errorCount;
	logic released;

	tbClock #(.halfPeriod(10), .resetCycles(5)) clk0 (
		.clk   (clk),
		.arstN (arstN)
	);

	hazardUnit dut0 (
		.clk     (clk),
		.arstN   (arstN),
		.instrD  (instrD),
		.mduBusy (mduBusy),
		.stall   (stall),
		.fwdRsD  (fwdRsD),
		.fwdRtD  (fwdRtD),
		.fwdRsE  (fwdRsE),
		.fwdRtE  (fwdRtE)
	);

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] encodeR(functT fn, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(opcodeT op, logic [4:0] rt, logic [4:0] rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Drive and compare
	//////////////////////////////////////////////////////////////////////

	task automatic checkBit(string sig, logic exp, logic act);
		if (act !== exp)
		begin
			$display("mismatch at %0t ns: %s expected %0b got %0b", $time, sig, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkSel(string sig, fwdSelT exp, fwdSelT act);
		if (act !== exp)
		begin
			$display("mismatch at %0t ns: %s expected %s got %s", $time, sig, exp.name(),
				act.name());
			errorCount++;
		end
	endtask

	// Drive on the falling edge, sample 2 ns before the rising edge
	task automatic driveAndCheck(logic [31:0] instr, logic busy, logic expStall,
		fwdSelT expRsD, fwdSelT expRtD, fwdSelT expRsE, fwdSelT expRtE);
		@(negedge clk);
		instrD = instr;
		mduBusy = busy;
		#8;
		checkBit("stall", expStall, stall);
		checkSel("fwdRsD", expRsD, fwdRsD);
		checkSel("fwdRtD", expRtD, fwdRtD);
		checkSel("fwdRsE", expRsE, fwdRsE);
		checkSel("fwdRtE", expRtE, fwdRtE);
	endtask

	// Three nops empty execute, memory and writeback
	task automatic flushPipe();
		repeat (3)
		begin
			@(negedge clk);
			instrD = 32'h0;
			mduBusy = 1'b0;
		end
	endtask

	task automatic waitReset(output logic ok);
		int waited;
		waited = 0;
		while (arstN !== 1'b1 && waited < 20)
		begin
			@(posedge clk);
			waited++;
		end
		ok = (arstN === 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetBehavior();
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
	endtask

	task automatic aluChain();
		// Back to back, producer sits in memory when consumer reaches execute
		flushPipe();
		driveAndCheck(encodeR(fnAdd, 5'd3, 5'd1, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnAdd, 5'd4, 5'd3, 5'd5), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdM, fwdReg);
		// One nop apart
		flushPipe();
		driveAndCheck(encodeR(fnAdd, 5'd3, 5'd1, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnAdd, 5'd4, 5'd3, 5'd5), 1'b0,
			1'b0, fwdM, fwdReg, fwdReg, fwdReg);
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdW, fwdReg);
		// Writes to r0 are never forwarded
		flushPipe();
		driveAndCheck(encodeR(fnAdd, 5'd0, 5'd1, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnAdd, 5'd6, 5'd0, 5'd0), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
	endtask

	task automatic loadUse();
		flushPipe();
		driveAndCheck(encodeI(opLw, 5'd2, 5'd1, 16'h0000), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnAdd, 5'd6, 5'd2, 5'd2), 1'b0,
			1'b1, fwdReg, fwdReg, fwdReg, fwdReg);
		// Held instruction, bubble now in execute
		driveAndCheck(encodeR(fnAdd, 5'd6, 5'd2, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		// Bubble in memory, load in writeback
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdW, fwdW);
	endtask

	task automatic branchAfterAlu();
		flushPipe();
		driveAndCheck(encodeR(fnAddu, 5'd7, 5'd1, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeI(opBeq, 5'd0, 5'd7, 16'h0004), 1'b0,
			1'b1, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeI(opBeq, 5'd0, 5'd7, 16'h0004), 1'b0,
			1'b0, fwdM, fwdReg, fwdReg, fwdReg);
		// Same hazard on the rt operand only
		flushPipe();
		driveAndCheck(encodeR(fnAddu, 5'd7, 5'd1, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeI(opBeq, 5'd7, 5'd0, 16'h0004), 1'b0,
			1'b1, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeI(opBeq, 5'd7, 5'd0, 16'h0004), 1'b0,
			1'b0, fwdReg, fwdM, fwdReg, fwdReg);
		// Link value is ready in execute
		flushPipe();
		driveAndCheck(encodeI(opJal, 5'd0, 5'd0, 16'h0040), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnJr, 5'd0, 5'd31, 5'd0), 1'b0,
			1'b0, fwdE, fwdReg, fwdReg, fwdReg);
	endtask

	task automatic storeData();
		flushPipe();
		driveAndCheck(encodeI(opLw, 5'd8, 5'd1, 16'h0000), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeI(opSw, 5'd8, 5'd1, 16'h0004), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		// Load still one cycle from its data
		driveAndCheck(32'h0, 1'b0, 1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
	endtask

	task automatic mduInterlock();
		flushPipe();
		driveAndCheck(encodeR(fnMult, 5'd0, 5'd1, 5'd2), 1'b1,
			1'b1, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnMult, 5'd0, 5'd1, 5'd2), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnMflo, 5'd9, 5'd0, 5'd0), 1'b1,
			1'b1, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnMflo, 5'd9, 5'd0, 5'd0), 1'b0,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
		driveAndCheck(encodeR(fnAdd, 5'd10, 5'd1, 5'd2), 1'b1,
			1'b0, fwdReg, fwdReg, fwdReg, fwdReg);
	endtask

	initial
	begin
		instrD = 32'h0;
		mduBusy = 1'b0;
		errorCount = 0;
		waitReset(released);
		if (!released)
		begin
			$display("reset was never released, giving up");
			errorCount++;
		end
		else
		begin
			resetBehavior();
			aluChain();
			loadUse();
			branchAfterAlu();
			storeData();
			mduInterlock();
		end
		$display("errors: %0d", errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hazardPkg.sv
atDecoder.sv
stageTracker.sv
stallControl.sv
forwardSelect.sv
hazardUnit.sv
tbClock.sv
tbHazardUnit.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tbHazardUnit -o simHazard

./obj_dir/simHazard | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
